// File: Bender.yml
package:
  name: vigna

sources:
  - src/vigna_pkg.sv
  - src/vigna_alu.sv
  - src/vigna_fetch.sv
  - src/vigna_decode.sv
  - src/vigna_regfile.sv
  - src/vigna_execute.sv
  - src/vigna_top.sv
  - target: test
    files:
      - verif/tb_vigna.sv

// File: build.f
src/vigna_pkg.sv
src/vigna_alu.sv
src/vigna_fetch.sv
src/vigna_decode.sv
src/vigna_regfile.sv
src/vigna_execute.sv
src/vigna_top.sv
verif/tb_vigna.sv

// File: src/vigna_alu.sv
`timescale 1ns/10ps

module vigna_alu (
    input  vigna_pkg::alu_op_e i_op,
    input  vigna_pkg::word_t   i_a,
    input  vigna_pkg::word_t   i_b,
    output vigna_pkg::word_t   o_result
);

    logic             sub;
    vigna_pkg::word_t sum;
    logic             eq;
    logic             abs_lt;
    logic             signed_lt;
    logic             unsigned_lt;

    // one adder, sub through inverted b and carry in
    assign sub = i_op == vigna_pkg::SUB;
    assign sum = i_a + (sub ? ~i_b : i_b) + {31'd0, sub};

    ////////////////////////////////////////////////////////////
    // compares from the sign bits and the low 31 bits
    assign eq          = i_a == i_b;
    assign abs_lt      = i_a[30:0] < i_b[30:0];
    assign signed_lt   = (i_a[31] ^ i_b[31]) ? i_a[31] : abs_lt;
    assign unsigned_lt = (i_a[31] ^ i_b[31]) ? i_b[31] : abs_lt;

    always_comb begin
        case (i_op)
            vigna_pkg::ADD,
            vigna_pkg::SUB:  o_result = sum;
            vigna_pkg::SLT,
            vigna_pkg::LT:   o_result = {31'd0, signed_lt};
            vigna_pkg::SLTU,
            vigna_pkg::LTU:  o_result = {31'd0, unsigned_lt};
            vigna_pkg::GE:   o_result = {31'd0, ~signed_lt};
            vigna_pkg::GEU:  o_result = {31'd0, ~unsigned_lt};
            vigna_pkg::EQ:   o_result = {31'd0, eq};
            vigna_pkg::NE:   o_result = {31'd0, ~eq};
            vigna_pkg::XOR:  o_result = i_a ^ i_b;
            vigna_pkg::OR:   o_result = i_a | i_b;
            vigna_pkg::AND:  o_result = i_a & i_b;
            default:         o_result = i_b;
        endcase
    end

endmodule

// File: src/vigna_decode.sv
`timescale 1ns/10ps

module vigna_decode (
    input  vigna_pkg::word_t     i_inst,
    input  vigna_pkg::word_t     i_inst_addr,
    output vigna_pkg::reg_addr_t o_rs1,
    output vigna_pkg::reg_addr_t o_rs2,
    output vigna_pkg::decoded_t  o_dec
);

    vigna_pkg::opcode_t opcode;
    vigna_pkg::funct3_t funct3;
    logic [6:0]         funct7;
    logic               alt;
    vigna_pkg::word_t   imm_i;
    vigna_pkg::word_t   imm_s;
    vigna_pkg::word_t   imm_b;
    vigna_pkg::word_t   imm_u;
    vigna_pkg::word_t   imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign alt    = funct7 == vigna_pkg::FUNCT7_ALT;
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    ////////////////////////////////////////////////////////////
    // immediates, all sign extended from bit 31
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'd0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        o_dec           = '0;
        o_dec.inst_addr = i_inst_addr;
        o_dec.rd        = i_inst[11:7];
        o_dec.imm       = imm_i;
        o_dec.alu_op    = vigna_pkg::PASS;
        case (opcode)
            vigna_pkg::OP_REG, vigna_pkg::OP_IMM: begin
                o_dec.use_imm   = opcode == vigna_pkg::OP_IMM;
                o_dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000: o_dec.alu_op = (alt && !o_dec.use_imm) ? vigna_pkg::SUB
                                                                   : vigna_pkg::ADD;
                    3'b001: o_dec.is_shift = 1'b1;
                    3'b010: o_dec.alu_op = vigna_pkg::SLT;
                    3'b011: o_dec.alu_op = vigna_pkg::SLTU;
                    3'b100: o_dec.alu_op = vigna_pkg::XOR;
                    3'b101: begin
                        o_dec.is_shift   = 1'b1;
                        o_dec.shift_kind = alt ? 2'b10 : 2'b01;
                    end
                    3'b110: o_dec.alu_op = vigna_pkg::OR;
                    default: o_dec.alu_op = vigna_pkg::AND;
                endcase
            end
            vigna_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    o_dec.is_load   = 1'b1;
                    o_dec.writes_rd = 1'b1;
                    o_dec.use_imm   = 1'b1;
                    o_dec.alu_op    = vigna_pkg::ADD;
                end
            end
            vigna_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin
                    o_dec.is_store = 1'b1;
                    o_dec.use_imm  = 1'b1;
                    o_dec.imm      = imm_s;
                    o_dec.alu_op   = vigna_pkg::ADD;
                end
            end
            vigna_pkg::OP_BRANCH: begin
                // rs1 vs rs2, imm kept for the target
                o_dec.imm       = imm_b;
                o_dec.is_branch = 1'b1;
                case (funct3)
                    3'b000: o_dec.alu_op = vigna_pkg::EQ;
                    3'b001: o_dec.alu_op = vigna_pkg::NE;
                    3'b100: o_dec.alu_op = vigna_pkg::LT;
                    3'b101: o_dec.alu_op = vigna_pkg::GE;
                    3'b110: o_dec.alu_op = vigna_pkg::LTU;
                    3'b111: o_dec.alu_op = vigna_pkg::GEU;
                    default: o_dec.is_branch = 1'b0;
                endcase
            end
            vigna_pkg::OP_JAL, vigna_pkg::OP_JALR: begin
                if (opcode == vigna_pkg::OP_JAL || funct3 == 3'b000) begin
                    o_dec.use_pc    = opcode == vigna_pkg::OP_JAL;
                    o_dec.imm       = o_dec.use_pc ? imm_j : imm_i;
                    o_dec.use_imm   = 1'b1;
                    o_dec.alu_op    = vigna_pkg::ADD;
                    o_dec.is_jump   = 1'b1;
                    o_dec.writes_rd = 1'b1;
                end
            end
            vigna_pkg::OP_LUI, vigna_pkg::OP_AUIPC: begin
                o_dec.imm       = imm_u;
                o_dec.zero_op1  = opcode == vigna_pkg::OP_LUI;
                o_dec.use_pc    = opcode == vigna_pkg::OP_AUIPC;
                o_dec.use_imm   = 1'b1;
                o_dec.alu_op    = vigna_pkg::ADD;
                o_dec.writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: src/vigna_execute.sv
`timescale 1ns/10ps

module vigna_execute (
    input  logic                clk,
    input  logic                resetn,
    input  vigna_pkg::decoded_t i_dec,
    input  logic                i_inst_ready,
    input  vigna_pkg::word_t    i_rs1_val,
    input  vigna_pkg::word_t    i_rs2_val,
    output logic                o_accept,
    output vigna_pkg::word_t    o_next_pc,
    output vigna_pkg::wb_t      o_wb,
    output logic                o_dmem_valid,
    output logic                o_dmem_we,
    output vigna_pkg::word_t    o_dmem_addr,
    output vigna_pkg::word_t    o_dmem_wdata,
    input  vigna_pkg::word_t    i_dmem_rdata,
    input  logic                i_dmem_ready
);

    vigna_pkg::exec_state_e state;
    vigna_pkg::alu_op_e     alu_op;
    vigna_pkg::word_t       op_a;
    vigna_pkg::word_t       op_b;
    vigna_pkg::word_t       op_c;
    vigna_pkg::word_t       result;
    vigna_pkg::word_t       op1;
    vigna_pkg::word_t       op2;
    vigna_pkg::word_t       seq_pc;
    vigna_pkg::word_t       shifted;
    vigna_pkg::shamt_t      count;
    vigna_pkg::reg_addr_t   wb_idx;
    logic                   wb_en;
    logic [1:0]             shift_kind;
    logic                   start;

    vigna_alu u_alu (
        .i_op     (alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (result)
    );

    assign start  = state == vigna_pkg::WAIT && i_inst_ready;
    assign op1    = i_dec.zero_op1 ? '0 : (i_dec.use_pc ? i_dec.inst_addr : i_rs1_val);
    assign op2    = i_dec.use_imm ? i_dec.imm : i_rs2_val;
    assign seq_pc = i_dec.inst_addr + 32'd4;

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= vigna_pkg::WAIT;
            o_dmem_valid <= 1'b0;
            o_dmem_we    <= 1'b0;
        end else begin
            case (state)
                vigna_pkg::WAIT: begin
                    if (i_inst_ready) begin
                        o_dmem_we <= i_dec.is_store;
                        if (i_dec.is_load || i_dec.is_store) state <= vigna_pkg::MEM_REQ;
                        else if (i_dec.is_jump)             state <= vigna_pkg::JUMP;
                        else if (i_dec.is_branch)           state <= vigna_pkg::BRANCH;
                        else if (i_dec.is_shift)            state <= vigna_pkg::SHIFT;
                        else                                state <= vigna_pkg::CALC;
                    end
                end
                vigna_pkg::MEM_REQ: begin
                    o_dmem_valid <= 1'b1;
                    state <= o_dmem_we ? vigna_pkg::STORE_WAIT : vigna_pkg::LOAD_WAIT;
                end
                vigna_pkg::LOAD_WAIT, vigna_pkg::STORE_WAIT: begin
                    if (i_dmem_ready) begin
                        o_dmem_valid <= 1'b0;
                        state        <= vigna_pkg::WAIT;
                    end
                end
                vigna_pkg::SHIFT: begin
                    if (count == '0) state <= vigna_pkg::WAIT;
                end
                default: state <= vigna_pkg::WAIT;
            endcase
        end
    end

    // one bit per cycle
    assign shifted = (shift_kind == 2'b00) ? {op_c[30:0], 1'b0}
                                           : {shift_kind[1] & op_c[31], op_c[31:1]};

    always_ff @(posedge clk) begin
        if (start) begin
            op_a       <= op1;
            op_b       <= op2;
            alu_op     <= i_dec.alu_op;
            count      <= op2[4:0];
            shift_kind <= i_dec.shift_kind;
            wb_idx     <= i_dec.rd;
            wb_en      <= i_dec.writes_rd;
            // store data, shift value, or link / branch target
            if (i_dec.is_store)      op_c <= i_rs2_val;
            else if (i_dec.is_shift) op_c <= op1;
            else op_c <= i_dec.inst_addr + (i_dec.is_branch ? i_dec.imm : 32'd4);
        end
        if (state == vigna_pkg::MEM_REQ) begin
            o_dmem_addr  <= result;
            o_dmem_wdata <= op_c;
        end
        if (state == vigna_pkg::SHIFT && count != '0) begin
            op_c  <= shifted;
            count <= count - 5'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // fetch handoff and writeback
    assign o_accept = (start && !i_dec.is_jump && !i_dec.is_branch)
                   || state == vigna_pkg::JUMP || state == vigna_pkg::BRANCH;

    always_comb begin
        if (state == vigna_pkg::JUMP)                      o_next_pc = {result[31:1], 1'b0};
        else if (state == vigna_pkg::BRANCH && result[0])  o_next_pc = op_c;
        else                                               o_next_pc = seq_pc;
    end

    always_comb begin
        o_wb.idx  = wb_idx;
        o_wb.en   = 1'b0;
        o_wb.data = op_c;
        case (state)
            vigna_pkg::CALC: begin
                o_wb.en   = wb_en;
                o_wb.data = result;
            end
            vigna_pkg::JUMP:  o_wb.en = wb_en;
            vigna_pkg::SHIFT: o_wb.en = wb_en && count == '0;
            vigna_pkg::LOAD_WAIT: begin
                o_wb.en   = wb_en && i_dmem_ready;
                o_wb.data = i_dmem_rdata;
            end
            default: ;
        endcase
    end

    a_dmem_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_dmem_valid && !i_dmem_ready |=> o_dmem_valid && $stable(o_dmem_addr));

endmodule

// File: src/vigna_fetch.sv
`timescale 1ns/10ps

module vigna_fetch (
    input  logic             clk,
    input  logic             resetn,
    output logic             o_imem_valid,
    output vigna_pkg::word_t o_imem_addr,
    input  logic             i_imem_ready,
    input  vigna_pkg::word_t i_imem_rdata,
    output vigna_pkg::word_t o_inst,
    output vigna_pkg::word_t o_inst_addr,
    output logic             o_inst_ready,
    input  logic             i_accept,
    input  vigna_pkg::word_t i_next_pc
);

    vigna_pkg::fetch_state_e state;
    vigna_pkg::word_t        pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= vigna_pkg::IDLE;
            pc           <= vigna_pkg::RESET_ADDR;
            o_imem_valid <= 1'b0;
        end else begin
            case (state)
                vigna_pkg::IDLE: begin
                    o_imem_valid <= 1'b1;
                    state        <= vigna_pkg::REQ;
                end
                vigna_pkg::REQ: begin
                    if (i_imem_ready) begin
                        o_imem_valid <= 1'b0;
                        state        <= vigna_pkg::HOLD;
                    end
                end
                default: begin
                    // held until execute takes it
                    if (i_accept) begin
                        pc           <= i_next_pc;
                        o_imem_valid <= 1'b1;
                        state        <= vigna_pkg::REQ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == vigna_pkg::REQ && i_imem_ready) begin
            o_inst <= i_imem_rdata;
        end
    end

    assign o_imem_addr  = pc;
    assign o_inst_addr  = pc;
    assign o_inst_ready = state == vigna_pkg::HOLD;

    a_addr_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_imem_valid && !i_imem_ready |=> $stable(o_imem_addr));

endmodule

// File: src/vigna_pkg.sv
package vigna_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [4:0]      shamt_t;

    localparam word_t RESET_ADDR = '0;

    ////////////////////////////////////////////////////////////
    // major opcodes
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // sub and sra / srai
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND,
        EQ, NE, LT, GE, LTU, GEU, PASS
    } alu_op_e;

    typedef enum logic [1:0] {IDLE, REQ, HOLD} fetch_state_e;

    typedef enum logic [2:0] {
        WAIT, CALC, MEM_REQ, LOAD_WAIT, STORE_WAIT, JUMP, BRANCH, SHIFT
    } exec_state_e;

    ////////////////////////////////////////////////////////////
    typedef struct packed {
        word_t     inst_addr;
        reg_addr_t rd;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      use_pc;
        logic      zero_op1;
        logic      writes_rd;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jump;
        logic      is_shift;
        // 00 left, 01 logical right, 10 arithmetic right
        logic [1:0] shift_kind;
    } decoded_t;

    typedef struct packed {
        logic      en;
        reg_addr_t idx;
        word_t     data;
    } wb_t;

endpackage

// File: src/vigna_regfile.sv
`timescale 1ns/10ps

module vigna_regfile (
    input  logic                 clk,
    input  vigna_pkg::reg_addr_t i_rs1,
    input  vigna_pkg::reg_addr_t i_rs2,
    output vigna_pkg::word_t     o_rs1_val,
    output vigna_pkg::word_t     o_rs2_val,
    input  vigna_pkg::wb_t       i_wb
);

    // x0 has no storage
    vigna_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (i_wb.en && i_wb.idx != '0) begin
            regs[i_wb.idx] <= i_wb.data;
        end
    end

    assign o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];

    a_x0_zero: assert property (@(posedge clk)
        i_wb.en && i_wb.idx == '0 |=>
            i_rs1 != $past(i_rs1) || o_rs1_val === $past(o_rs1_val));

endmodule

// File: src/vigna_top.sv
`timescale 1ns/10ps

module vigna_top (
    input  logic             clk,
    input  logic             resetn,
    output logic             o_imem_valid,
    output vigna_pkg::word_t o_imem_addr,
    input  logic             i_imem_ready,
    input  vigna_pkg::word_t i_imem_rdata,
    output logic             o_dmem_valid,
    output logic             o_dmem_we,
    output vigna_pkg::word_t o_dmem_addr,
    output vigna_pkg::word_t o_dmem_wdata,
    input  logic             i_dmem_ready,
    input  vigna_pkg::word_t i_dmem_rdata
);

    vigna_pkg::word_t     inst;
    vigna_pkg::word_t     inst_addr;
    logic                 inst_ready;
    logic                 accept;
    vigna_pkg::word_t     next_pc;
    vigna_pkg::reg_addr_t rs1;
    vigna_pkg::reg_addr_t rs2;
    vigna_pkg::word_t     rs1_val;
    vigna_pkg::word_t     rs2_val;
    vigna_pkg::decoded_t  dec;
    vigna_pkg::wb_t       wb;

    vigna_fetch u_fetch (
        .clk          (clk),
        .resetn       (resetn),
        .o_imem_valid (o_imem_valid),
        .o_imem_addr  (o_imem_addr),
        .i_imem_ready (i_imem_ready),
        .i_imem_rdata (i_imem_rdata),
        .o_inst       (inst),
        .o_inst_addr  (inst_addr),
        .o_inst_ready (inst_ready),
        .i_accept     (accept),
        .i_next_pc    (next_pc)
    );

    vigna_decode u_decode (
        .i_inst      (inst),
        .i_inst_addr (inst_addr),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_dec       (dec)
    );

    vigna_regfile u_regfile (
        .clk       (clk),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val),
        .i_wb      (wb)
    );

    vigna_execute u_execute (
        .clk          (clk),
        .resetn       (resetn),
        .i_dec        (dec),
        .i_inst_ready (inst_ready),
        .i_rs1_val    (rs1_val),
        .i_rs2_val    (rs2_val),
        .o_accept     (accept),
        .o_next_pc    (next_pc),
        .o_wb         (wb),
        .o_dmem_valid (o_dmem_valid),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .i_dmem_ready (i_dmem_ready)
    );

endmodule

// File: verif/tb_vigna.sv
`timescale 1ns/10ps

module tb_vigna;

    localparam int          CLK_HALF  = 20;
    localparam int          MAX_CPI   = 64;
    localparam logic [31:0] OUT_BASE  = 32'h400;
    localparam logic [31:0] MARKER    = 32'h7fc;

    typedef struct packed {
        logic [2:0] f3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       taken;
    } branch_case_t;

    typedef struct packed {
        logic [6:0]       f7;
        logic [2:0]       f3;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        vigna_pkg::word_t result;
    } alu_case_t;

    logic             clk;
    logic             resetn;
    logic             o_imem_valid;
    vigna_pkg::word_t o_imem_addr;
    logic             i_imem_ready;
    vigna_pkg::word_t i_imem_rdata;
    logic             o_dmem_valid;
    logic             o_dmem_we;
    vigna_pkg::word_t o_dmem_addr;
    vigna_pkg::word_t o_dmem_wdata;
    logic             i_dmem_ready;
    vigna_pkg::word_t i_dmem_rdata;

    vigna_pkg::word_t imem [0:255];
    vigna_pkg::word_t dmem [0:1023];
    vigna_pkg::word_t exp_addr [$];
    vigna_pkg::word_t exp_data [$];
    vigna_pkg::word_t pc_b;
    vigna_pkg::word_t out_addr;
    int               prog_len;
    int               n_seen;
    logic             built;
    logic             done;

    vigna_top dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .o_imem_valid (o_imem_valid),
        .o_imem_addr  (o_imem_addr),
        .i_imem_ready (i_imem_ready),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem_valid (o_dmem_valid),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // instruction encoders
    function automatic vigna_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic vigna_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic vigna_pkg::word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic vigna_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic vigna_pkg::word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input vigna_pkg::word_t w);
        imem[pc_b[9:2]] = w;
        pc_b = pc_b + 4;
    endtask

    // sw rs to the next result slot
    task automatic store_result(input int rs, input vigna_pkg::word_t value);
        emit(enc_s(out_addr, rs, 0));
        exp_addr.push_back(out_addr);
        exp_data.push_back(value);
        out_addr = out_addr + 4;
    endtask

    task automatic check_value(input string name, input vigna_pkg::word_t expected,
                               input vigna_pkg::word_t actual);
        if (expected !== actual) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected,
                     actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    task automatic build_program();
        vigna_pkg::word_t v1;
        vigna_pkg::word_t v2;
        vigna_pkg::word_t v7;
        vigna_pkg::word_t p;
        alu_case_t        alu_tab [9];
        branch_case_t     br_tab [12];
        int               amts [3];
        v1 = -32'sd5;
        v2 = 32'd3;
        v7 = 32'h80001234;
        amts = '{0, 1, 31};
        alu_tab = '{
            '{7'h00, 3'b000, 5'd1, 5'd2, v1 + v2},
            '{7'h20, 3'b000, 5'd2, 5'd1, v2 - v1},
            '{7'h00, 3'b010, 5'd1, 5'd2, 32'd1},   // -5 < 3 signed
            '{7'h00, 3'b011, 5'd1, 5'd2, 32'd0},
            '{7'h00, 3'b010, 5'd2, 5'd1, 32'd0},
            '{7'h00, 3'b011, 5'd2, 5'd1, 32'd1},
            '{7'h00, 3'b100, 5'd1, 5'd2, v1 ^ v2},
            '{7'h00, 3'b110, 5'd1, 5'd2, v1 | v2},
            '{7'h00, 3'b111, 5'd1, 5'd2, v1 & v2}
        };
        // x1 = -5, x2 = 3
        br_tab = '{
            '{3'b000, 5'd1, 5'd1, 1'b1}, '{3'b000, 5'd1, 5'd2, 1'b0},
            '{3'b001, 5'd1, 5'd2, 1'b1}, '{3'b001, 5'd1, 5'd1, 1'b0},
            '{3'b100, 5'd1, 5'd2, 1'b1}, '{3'b100, 5'd2, 5'd1, 1'b0},
            '{3'b101, 5'd2, 5'd1, 1'b1}, '{3'b101, 5'd1, 5'd2, 1'b0},
            '{3'b110, 5'd2, 5'd1, 1'b1}, '{3'b110, 5'd1, 5'd2, 1'b0},
            '{3'b111, 5'd1, 5'd2, 1'b1}, '{3'b111, 5'd2, 5'd1, 1'b0}
        };
        pc_b = '0;
        out_addr = OUT_BASE;
        foreach (imem[i]) imem[i] = '0;

        emit(enc_i(-5, 0, 0, 1, 7'b0010011));
        emit(enc_i(3, 0, 0, 2, 7'b0010011));
        foreach (alu_tab[i]) begin
            emit(enc_r(alu_tab[i].f7, alu_tab[i].rs2, alu_tab[i].rs1, alu_tab[i].f3, 3));
            store_result(3, alu_tab[i].result);
        end
        emit(enc_i(100, 1, 3'b000, 3, 7'b0010011));
        store_result(3, v1 + 100);
        emit(enc_i(-4, 1, 3'b010, 3, 7'b0010011));
        store_result(3, 32'd1);
        emit(enc_i(-1, 2, 3'b011, 3, 7'b0010011));
        store_result(3, 32'd1);
        emit(enc_i(12'h0f0, 1, 3'b100, 3, 7'b0010011));
        store_result(3, v1 ^ 32'h0f0);
        emit(enc_i(12'h700, 2, 3'b110, 3, 7'b0010011));
        store_result(3, v2 | 32'h700);
        emit(enc_i(12'h7f0, 1, 3'b111, 3, 7'b0010011));
        store_result(3, v1 & 32'h7f0);

        // shifts on x7
        emit({20'h80001, 5'd7, 7'b0110111});
        emit(enc_i(12'h234, 7, 3'b000, 7, 7'b0010011));
        store_result(7, v7);
        foreach (amts[i]) begin
            emit(enc_i(amts[i], 7, 3'b001, 3, 7'b0010011));
            store_result(3, v7 << amts[i]);
            emit(enc_i(amts[i], 7, 3'b101, 3, 7'b0010011));
            store_result(3, v7 >> amts[i]);
            emit(enc_i(12'h400 | amts[i], 7, 3'b101, 3, 7'b0010011));
            store_result(3, vigna_pkg::word_t'($signed(v7) >>> amts[i]));
        end
        emit(enc_r(7'h00, 2, 7, 3'b001, 3));
        store_result(3, v7 << 3);
        emit(enc_r(7'h00, 2, 7, 3'b101, 3));
        store_result(3, v7 >> 3);
        emit(enc_r(7'h20, 2, 7, 3'b101, 3));
        store_result(3, vigna_pkg::word_t'($signed(v7) >>> 3));

        // taken branch skips the addi
        foreach (br_tab[i]) begin
            emit(enc_i(0, 0, 3'b000, 10, 7'b0010011));
            emit(enc_b(8, br_tab[i].rs2, br_tab[i].rs1, br_tab[i].f3));
            emit(enc_i(1, 0, 3'b000, 10, 7'b0010011));
            store_result(10, br_tab[i].taken ? 32'd0 : 32'd1);
        end

        // count x5 up to x6
        emit(enc_i(0, 0, 3'b000, 5, 7'b0010011));
        emit(enc_i(5, 0, 3'b000, 6, 7'b0010011));
        emit(enc_i(1, 5, 3'b000, 5, 7'b0010011));
        emit(enc_b(-4, 6, 5, 3'b001));
        store_result(5, 32'd5);

        emit({20'habcde, 5'd3, 7'b0110111});
        store_result(3, 32'habcde000);
        p = pc_b;
        emit({20'h12345, 5'd3, 7'b0010111});
        store_result(3, 32'h12345000 + p);

        p = pc_b;
        emit(enc_j(8, 3));
        emit(enc_i(0, 0, 3'b000, 3, 7'b0010011));
        store_result(3, p + 4);
        p = pc_b;
        emit(enc_i(p + 12, 0, 3'b000, 4, 7'b0010011));
        emit(enc_i(4, 4, 3'b000, 3, 7'b1100111));
        emit(enc_i(0, 0, 3'b000, 3, 7'b0010011));
        emit(enc_i(0, 0, 3'b000, 3, 7'b0010011));
        store_result(3, p + 8);

        emit(enc_i(12'h080, 0, 3'b010, 8, 7'b0000011));
        store_result(8, 32'hdeadbeef);
        emit(enc_i(12'h084, 0, 3'b010, 9, 7'b0000011));
        store_result(9, 32'h0badf00d);

        emit(enc_i(123, 0, 3'b000, 0, 7'b0010011));
        store_result(0, 32'd0);

        // end marker, then spin in place
        emit(enc_s(MARKER, 0, 0));
        emit(enc_j(0, 0));
        prog_len = pc_b / 4;
    endtask

    ////////////////////////////////////////////////////////////
    // instruction bus model
    initial begin
        int  wait_cnt;
        logic busy;
        busy = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (i_imem_ready) begin
                i_imem_ready = 1'b0;
                busy = 1'b0;
            end else if (o_imem_valid) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_cnt = $urandom % 4;
                end
                if (wait_cnt == 0) begin
                    i_imem_ready = 1'b1;
                    i_imem_rdata = imem[o_imem_addr[9:2]];
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // data bus model, stores checked as they complete
    initial begin
        int  wait_cnt;
        logic busy;
        busy = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (i_dmem_ready) begin
                i_dmem_ready = 1'b0;
                busy = 1'b0;
            end else if (o_dmem_valid) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_cnt = $urandom % 4;
                end
                if (wait_cnt == 0) begin
                    i_dmem_ready = 1'b1;
                    if (!o_dmem_we) begin
                        i_dmem_rdata = dmem[o_dmem_addr[11:2]];
                    end else if (o_dmem_addr == MARKER) begin
                        done = 1'b1;
                    end else if (n_seen >= exp_addr.size()) begin
                        $display("Unexpected extra store to %h at %0t ns", o_dmem_addr, $time);
                        $display("Simulation failed");
                        $fatal(1);
                    end else begin
                        check_value("o_dmem_addr", exp_addr[n_seen], o_dmem_addr);
                        check_value("o_dmem_wdata", exp_data[n_seen], o_dmem_wdata);
                        dmem[o_dmem_addr[11:2]] = o_dmem_wdata;
                        n_seen++;
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    initial begin
        int seed;
        seed = $urandom(71765);
        resetn = 1'b0;
        i_imem_ready = 1'b0;
        i_imem_rdata = '0;
        i_dmem_ready = 1'b0;
        i_dmem_rdata = '0;
        n_seen = 0;
        done = 1'b0;
        built = 1'b0;
        build_program();
        foreach (dmem[i]) dmem[i] = (i * 4) ^ 32'ha5a5_3c3c;
        dmem[32] = 32'hdeadbeef;
        dmem[33] = 32'h0badf00d;
        built = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        wait (done);
        @(posedge clk);
        if (n_seen == exp_addr.size()) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Marker store came after %0d of %0d results", n_seen, exp_addr.size());
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // watchdog
    initial begin
        time limit;
        wait (built);
        limit = prog_len * MAX_CPI * 2 * CLK_HALF;
        #(limit);
        $display("Program never reached the marker store within %0t ns", limit);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule
